//--- eth_link_bridge.f
hdl/eth_link_pkg.sv
hdl/frame_fifo.sv
hdl/eth_port_channel.sv
hdl/link_port_mux.sv
hdl/blink_timer.sv
hdl/eth_link_bridge.sv
testbench/eth_link_bridge_assertions.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_eth_link_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the port switch testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_eth_link_bridge \
    -f eth_link_bridge.f -o vsim || { echo "build failed"; exit 1; }

./obj_dir/vsim > "$LOG" 2>&1 || echo "simulator returned an error status" >> "$LOG"
cat "$LOG"

grep -q "Simulation FAILED" "$LOG" && { echo "run failed"; exit 1; }
grep -q "Simulation PASSED" "$LOG" || { echo "run ended without a result"; exit 1; }
exit 0

//--- testbench/tb_eth_link_bridge.sv
/*
 * port switch testbench top
 * stimulus table applied row by row, checker and timeout
 */
`timescale 1ns/100ps

module tb_eth_link_bridge;

    localparam int NPORTS        = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int CLK_PER_US    = 2;
    localparam int BLINK_HALF_MS = 2;
    localparam int LED_PERIOD    = CLK_PER_US * 1000 * BLINK_HALF_MS;
    localparam int NROWS         = 10;

    // ready patterns
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_RANDOM = 1;
    localparam int RDY_HOLD   = 2;
    // expected outcomes
    localparam int EXP_NONE     = 0;
    localparam int EXP_DELIVER  = 1;
    localparam int EXP_OVERFLOW = 2;

    // blink rows use len as their end cycle after reset release
    typedef struct {
        int blink;
        int port;
        int sel;
        int sel_link;
        int lock;
        int status;
        int len;
        int rdy;
        int rx_len;
        int outcome;
    } row_t;

    logic                       clk20_g;
    logic                       arst_n_i;
    eth_link_pkg::port_sel_t    sel_eth_ch;
    logic                       sel_link;
    logic                       link_tx_lock;
    logic                       link_rst;
    eth_link_pkg::mac_status_t  mac_status [NPORTS];
    eth_link_pkg::mac_rx_beat_t mac_rx [NPORTS];
    logic                       link_tx_ready;
    eth_link_pkg::link_beat_t   link_rx;
    eth_link_pkg::link_beat_t   link_tx;
    eth_link_pkg::mac_tx_beat_t mac_tx [NPORTS];
    logic [NPORTS-1:0]          rx_overflow;
    logic                       led;

    row_t  rows [NROWS];
    string desc [NROWS];
    int    seed = 32'hb0f370cd;
    int    cyc = 0;
    int    limit_cycles = 0;

    tb_clock_gen clk_inst (
        .clk20_g  (clk20_g),
        .arst_n_i (arst_n_i)
    );

    eth_link_bridge #(
        .nports        (NPORTS),
        .fifo_depth    (FIFO_DEPTH),
        .clk_per_us    (CLK_PER_US),
        .blink_half_ms (BLINK_HALF_MS)
    ) eth_link_bridge_inst (
        .clk20_g         (clk20_g),
        .arst_n_i        (arst_n_i),
        .sel_eth_ch_i    (sel_eth_ch),
        .sel_link_i      (sel_link),
        .link_tx_lock_i  (link_tx_lock),
        .link_rst_i      (link_rst),
        .mac_status_i    (mac_status),
        .mac_rx_i        (mac_rx),
        .link_tx_ready_i (link_tx_ready),
        .link_rx_i       (link_rx),
        .link_tx_o       (link_tx),
        .mac_tx_o        (mac_tx),
        .rx_overflow_o   (rx_overflow),
        .led_o           (led)
    );

    tb_checker #(
        .nports     (NPORTS),
        .led_period (LED_PERIOD)
    ) chk_inst (
        .clk20_g         (clk20_g),
        .arst_n_i        (arst_n_i),
        .link_tx_ready_i (link_tx_ready),
        .link_rst_i      (link_rst),
        .link_tx_i       (link_tx),
        .mac_tx_i        (mac_tx),
        .rx_overflow_i   (rx_overflow),
        .led_i           (led)
    );

    // --------------------
    // helpers
    // --------------------
    function automatic logic ready_value(input int mode);
        logic r;
        if (mode == RDY_RANDOM) begin
            r = 1'($random(seed));
        end else if (mode == RDY_HOLD) begin
            r = 1'b0;
        end else begin
            r = 1'b1;
        end
        return r;
    endfunction

    // row lengths plus gap and drain allowance
    function automatic int calc_limit();
        int sum;
        sum = 0;
        for (int r = 0; r < NROWS; r++) begin
            if (rows[r].blink != 0) begin
                sum += rows[r].len + 20;
            end else begin
                sum += 15 + rows[r].len + rows[r].rx_len + 4 * FIFO_DEPTH + 20;
            end
        end
        return sum + sum / 4 + 100;
    endfunction

    task automatic run_frame_row(input row_t r);
        eth_link_pkg::mac_rx_beat_t b;
        eth_link_pkg::link_beat_t   lb;
        int                         n;
        // gap with the link deselected flushes every port
        @(posedge clk20_g);
        sel_link      <= 1'b0;
        link_tx_ready <= 1'b1;
        for (int p = 0; p < NPORTS; p++) begin
            mac_status[p] <= '0;
        end
        repeat (3) @(posedge clk20_g);
        sel_eth_ch                <= eth_link_pkg::port_sel_t'(r.sel);
        sel_link                  <= (r.sel_link != 0);
        link_tx_lock              <= (r.lock != 0);
        mac_status[r.port]        <= eth_link_pkg::mac_status_t'(4'(r.status));
        repeat (2) @(posedge clk20_g);
        n = (r.len > r.rx_len) ? r.len : r.rx_len;
        for (int i = 0; i < n; i++) begin
            @(posedge clk20_g);
            b  = '0;
            lb = '0;
            if (i < r.len) begin
                b.valid = 1'b1;
                b.data  = 8'($random(seed));
                b.last  = (i == r.len - 1);
                b.bad   = 1'($random(seed));
                if (r.outcome == EXP_DELIVER ||
                    (r.outcome == EXP_OVERFLOW && i < FIFO_DEPTH)) begin
                    chk_inst.expect_link(b.data, b.last, b.bad);
                end
            end
            if (i < r.rx_len) begin
                lb.valid = 1'b1;
                lb.data  = 8'($random(seed));
                lb.last  = (i == r.rx_len - 1);
                chk_inst.expect_mac(eth_link_pkg::port_sel_t'(r.sel), lb.data,
                                    (i == 0), lb.last);
            end
            mac_rx[r.port] <= b;
            link_rx        <= lb;
            link_tx_ready  <= ready_value(r.rdy);
        end
        @(posedge clk20_g);
        mac_rx[r.port] <= '0;
        link_rx        <= '0;
        // overflow flag of this port only, ready still low
        if (r.outcome == EXP_OVERFLOW) begin
            repeat (3) @(posedge clk20_g);
            @(negedge clk20_g);
            chk_inst.check_overflow(NPORTS'(1 << r.port));
        end
        while (chk_inst.pending() != 0) begin
            @(posedge clk20_g);
            link_tx_ready <= ready_value((r.rdy == RDY_HOLD) ? RDY_ALWAYS : r.rdy);
        end
        @(posedge clk20_g);
        link_tx_ready <= 1'b1;
        // idle window catches stray beats
        repeat (10) @(posedge clk20_g);
    endtask

    task automatic run_blink_row(input row_t r);
        @(posedge clk20_g);
        // mask the led inside its first lit half period
        while (chk_inst.edge_cnt < LED_PERIOD + LED_PERIOD / 4) begin
            @(posedge clk20_g);
        end
        link_rst <= 1'b1;
        repeat (LED_PERIOD / 8) @(posedge clk20_g);
        link_rst <= 1'b0;
        // run on past the toggle back to dark
        while (chk_inst.edge_cnt < r.len) begin
            @(posedge clk20_g);
        end
    endtask

    // --------------------
    // timeout
    // --------------------
    always @(posedge clk20_g) begin
        cyc <= cyc + 1;
        if (limit_cycles != 0 && cyc > limit_cycles) begin
            $display("timeout: run did not finish within %0d cycles", limit_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------
    // stimulus table and loop
    // --------------------
    initial begin
        sel_eth_ch    = '0;
        sel_link      = 1'b0;
        link_tx_lock  = 1'b0;
        link_rst      = 1'b0;
        link_tx_ready = 1'b1;
        link_rx       = '0;
        for (int p = 0; p < NPORTS; p++) begin
            mac_status[p] = '0;
            mac_rx[p]     = '0;
        end

        // blink port sel link lock status len rdy rx_len outcome
        rows[0] = '{0, 1, 1, 1, 1, 5, 8, RDY_ALWAYS, 0, EXP_DELIVER};
        desc[0] = "frame on selected port";
        rows[1] = '{0, 2, 1, 1, 1, 5, 6, RDY_ALWAYS, 0, EXP_NONE};
        desc[1] = "frame on other port";
        rows[2] = '{0, 0, 0, 0, 1, 5, 6, RDY_ALWAYS, 0, EXP_NONE};
        desc[2] = "link not selected";
        rows[3] = '{0, 3, 3, 1, 0, 5, 6, RDY_ALWAYS, 0, EXP_NONE};
        desc[3] = "transceiver not locked";
        rows[4] = '{0, 2, 2, 1, 1, 3, 6, RDY_ALWAYS, 0, EXP_NONE};
        desc[4] = "status not 1G";
        rows[5] = '{0, 3, 3, 1, 1, 5, 12, RDY_RANDOM, 0, EXP_DELIVER};
        desc[5] = "random ready";
        rows[6] = '{0, 0, 0, 1, 1, 5, 20, RDY_HOLD, 0, EXP_OVERFLOW};
        desc[6] = "overflow with ready low";
        rows[7] = '{0, 2, 2, 1, 1, 5, 0, RDY_ALWAYS, 7, EXP_NONE};
        desc[7] = "link rx to mac tx";
        rows[8] = '{0, 1, 1, 1, 1, 5, 5, RDY_RANDOM, 5, EXP_DELIVER};
        desc[8] = "both directions";
        rows[9] = '{1, 0, 0, 0, 0, 0, 9000, RDY_ALWAYS, 0, EXP_NONE};
        desc[9] = "led blink";
        limit_cycles = calc_limit();

        wait (arst_n_i == 1'b1);
        for (int r = 0; r < NROWS; r++) begin
            if (rows[r].blink != 0) begin
                run_blink_row(rows[r]);
            end else begin
                run_frame_row(rows[r]);
            end
            chk_inst.end_test(r, desc[r]);
        end

        chk_inst.report();
        if (chk_inst.err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_checker.sv
/*
 * port switch checker
 * expected beat queues, led model, per test and closing reports
 */
`timescale 1ns/100ps

module tb_checker #(
    parameter int nports     = 4,
    parameter int led_period = 4000
) (
    input logic                       clk20_g,
    input logic                       arst_n_i,
    input logic                       link_tx_ready_i,
    input logic                       link_rst_i,
    input eth_link_pkg::link_beat_t   link_tx_i,
    input eth_link_pkg::mac_tx_beat_t mac_tx_i [nports],
    input logic [nports-1:0]          rx_overflow_i,
    input logic                       led_i
);

    typedef struct packed {
        eth_link_pkg::port_sel_t    port;
        eth_link_pkg::mac_tx_beat_t beat;
    } mac_exp_t;

    eth_link_pkg::link_beat_t link_q [$];
    mac_exp_t                 mac_q [$];
    int                       err_cnt = 0;
    int                       test_base = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    int                       edge_cnt;

    task automatic expect_link(input eth_link_pkg::byte_t d, input logic last, input logic bad);
        eth_link_pkg::link_beat_t b;
        b.valid = 1'b1;
        b.data  = d;
        b.last  = last;
        b.bad   = bad;
        link_q.push_back(b);
    endtask

    task automatic expect_mac(input eth_link_pkg::port_sel_t p, input eth_link_pkg::byte_t d,
                              input logic sof, input logic last);
        mac_exp_t m;
        m.port       = p;
        m.beat.valid = 1'b1;
        m.beat.data  = d;
        m.beat.sof   = sof;
        m.beat.last  = last;
        mac_q.push_back(m);
    endtask

    function automatic int pending();
        return link_q.size() + mac_q.size();
    endfunction

    task automatic check_overflow(input logic [nports-1:0] exp);
        if (rx_overflow_i !== exp) begin
            $display("Mismatch at %0t: rx_overflow_o is %b, expected %b",
                     $time, rx_overflow_i, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input int idx, input string name);
        if (pending() != 0) begin
            $display("test %0d: %0d expected beats never arrived", idx, pending());
            err_cnt++;
            link_q.delete();
            mac_q.delete();
        end
        tests_run++;
        if (err_cnt != test_base) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", idx, name, err_cnt - test_base);
        end else begin
            $display("test %0d %s: ok", idx, name);
        end
        test_base = err_cnt;
    endtask

    task automatic report();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    endtask

    // edges since reset release, drives the led model
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    // --------------------
    // monitors
    // --------------------
    always @(posedge clk20_g) begin
        eth_link_pkg::link_beat_t exp_l;
        mac_exp_t                 exp_m;
        logic                     led_exp;
        if (arst_n_i) begin
            // link side transfer
            if (link_tx_i.valid && link_tx_ready_i) begin
                if (link_q.size() == 0) begin
                    $display("Mismatch at %0t: unexpected link_tx beat %h", $time, link_tx_i);
                    err_cnt++;
                end else begin
                    exp_l = link_q.pop_front();
                    if (link_tx_i !== exp_l) begin
                        $display("Mismatch at %0t: link_tx beat %h, expected %h",
                                 $time, link_tx_i, exp_l);
                        err_cnt++;
                    end
                end
            end
            // mac transmit, any port
            for (int p = 0; p < nports; p++) begin
                if (mac_tx_i[p].valid) begin
                    if (mac_q.size() == 0) begin
                        $display("Mismatch at %0t: unexpected mac_tx beat on port %0d",
                                 $time, p);
                        err_cnt++;
                    end else begin
                        exp_m = mac_q.pop_front();
                        if (exp_m.port != eth_link_pkg::port_sel_t'(p) ||
                            mac_tx_i[p] !== exp_m.beat) begin
                            $display("Mismatch at %0t: mac_tx port %0d beat %h, expected %0d %h",
                                     $time, p, mac_tx_i[p], exp_m.port, exp_m.beat);
                            err_cnt++;
                        end
                    end
                end
            end
            // blink toggles every led_period edges, dark in link reset
            led_exp = ((edge_cnt / led_period) % 2 == 1) && !link_rst_i;
            if (led_i !== led_exp) begin
                $display("Mismatch at %0t: led_o is %b, expected %b", $time, led_i, led_exp);
                err_cnt++;
            end
        end
    end

endmodule

//--- testbench/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * 10 ns clock, reset held low for the first cycles
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int half_period = 5,
    parameter int rst_cycles  = 10
) (
    output logic clk20_g,
    output logic arst_n_i
);

    initial begin
        clk20_g = 1'b0;
        forever #half_period clk20_g = ~clk20_g;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arst_n_i = 1'b0;
        repeat (rst_cycles) @(posedge clk20_g);
        @(negedge clk20_g);
        arst_n_i = 1'b1;
    end

endmodule

//--- testbench/eth_link_bridge_assertions.sv
/*
 * bound stream assertions for the port switch top
 */
`timescale 1ns/100ps

module eth_link_bridge_assertions #(
    parameter int nports = 4
) (
    input logic                       clk20_g,
    input logic                       arst_n_i,
    input logic                       link_tx_ready_i,
    input eth_link_pkg::link_beat_t   link_tx_o,
    input eth_link_pkg::mac_tx_beat_t mac_tx_o [nports]
);

    logic [nports-1:0] mac_valids;

    always_comb begin
        for (int i = 0; i < nports; i++) begin
            mac_valids[i] = mac_tx_o[i].valid;
        end
    end

    // stalled beat holds
    assert property (@(posedge clk20_g) disable iff (!arst_n_i)
        (link_tx_o.valid && !link_tx_ready_i) |=> $stable(link_tx_o))
        else $error("link_tx_o changed while valid and not ready");

    // quiet outputs in reset
    assert property (@(posedge clk20_g)
        !arst_n_i |-> (!link_tx_o.valid && mac_valids == '0))
        else $error("valid output high during reset");

    assert property (@(posedge clk20_g) disable iff (!arst_n_i) $onehot0(mac_valids))
        else $error("more than one mac_tx_o port valid");

endmodule

bind eth_link_bridge eth_link_bridge_assertions #(
    .nports (nports)
) assertions_inst (
    .clk20_g         (clk20_g),
    .arst_n_i        (arst_n_i),
    .link_tx_ready_i (link_tx_ready_i),
    .link_tx_o       (link_tx_o),
    .mac_tx_o        (mac_tx_o)
);

//--- hdl/eth_link_bridge.sv
/*
 * ethernet to serial link bridge
 * port channels, link mux and debug blinker on clk20_g
 */
`timescale 1ns/100ps

module eth_link_bridge #(
    parameter int nports        = eth_link_pkg::NPORTS_DEF,
    parameter int fifo_depth    = eth_link_pkg::FIFO_DEPTH_DEF,
    parameter int clk_per_us    = eth_link_pkg::CLK_PER_US_DEF,
    parameter int blink_half_ms = eth_link_pkg::BLINK_HALF_MS_DEF
) (
    input  logic                       clk20_g,
    input  logic                       arst_n_i,
    // control levels
    input  eth_link_pkg::port_sel_t    sel_eth_ch_i,
    input  logic                       sel_link_i,
    input  logic                       link_tx_lock_i,
    input  logic                       link_rst_i,
    // mac side
    input  eth_link_pkg::mac_status_t  mac_status_i [nports],
    input  eth_link_pkg::mac_rx_beat_t mac_rx_i [nports],
    // link side
    input  logic                       link_tx_ready_i,
    input  eth_link_pkg::link_beat_t   link_rx_i,
    output eth_link_pkg::link_beat_t   link_tx_o,
    // mac transmit and status
    output eth_link_pkg::mac_tx_beat_t mac_tx_o [nports],
    output logic [nports-1:0]          rx_overflow_o,
    output logic                       led_o
);

    // per port heads, pops and pushes between channels and mux
    eth_link_pkg::link_beat_t rx_heads [nports];
    logic [nports-1:0]        rx_pops;
    eth_link_pkg::link_beat_t tx_pushes [nports];

    // --------------------
    // port channels
    // --------------------
    for (genvar p = 0; p < nports; p++) begin : g_port
        eth_port_channel #(
            .port_idx   (p),
            .fifo_depth (fifo_depth)
        ) port_inst (
            .clk20_g        (clk20_g),
            .arst_n_i       (arst_n_i),
            .sel_eth_ch_i   (sel_eth_ch_i),
            .sel_link_i     (sel_link_i),
            .link_tx_lock_i (link_tx_lock_i),
            .mac_status_i   (mac_status_i[p]),
            .mac_rx_i       (mac_rx_i[p]),
            .rx_head_o      (rx_heads[p]),
            .rx_pop_i       (rx_pops[p]),
            .tx_push_i      (tx_pushes[p]),
            .mac_tx_o       (mac_tx_o[p]),
            .overflow_o     (rx_overflow_o[p])
        );
    end

    // --------------------
    // link mux
    // --------------------
    link_port_mux #(
        .nports (nports)
    ) mux_inst (
        .sel_eth_ch_i    (sel_eth_ch_i),
        .rx_heads_i      (rx_heads),
        .rx_pops_o       (rx_pops),
        .link_tx_ready_i (link_tx_ready_i),
        .link_tx_o       (link_tx_o),
        .link_rx_i       (link_rx_i),
        .tx_pushes_o     (tx_pushes)
    );

    // --------------------
    // debug led
    // --------------------
    blink_timer #(
        .clk_per_us    (clk_per_us),
        .blink_half_ms (blink_half_ms)
    ) blink_inst (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .link_rst_i (link_rst_i),
        .led_o      (led_o)
    );

endmodule

//--- hdl/blink_timer.sv
/*
 * debug led blinker
 * microsecond and millisecond tick chain, toggles every blink_half_ms
 */
`timescale 1ns/100ps

module blink_timer #(
    parameter int clk_per_us    = eth_link_pkg::CLK_PER_US_DEF,
    parameter int blink_half_ms = eth_link_pkg::BLINK_HALF_MS_DEF
) (
    input  logic clk20_g,
    input  logic arst_n_i,
    input  logic link_rst_i,
    output logic led_o
);

    localparam int US_W   = $clog2(clk_per_us + 1);
    localparam int MS_W   = $clog2(1000 + 1);
    localparam int HALF_W = $clog2(blink_half_ms + 1);

    logic [US_W-1:0]   us_cnt_q;
    logic [MS_W-1:0]   ms_cnt_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic              us_tick;
    logic              ms_tick;
    logic              half_tick;
    logic              blink_q;

    // tick on the last count of each stage
    assign us_tick   = (us_cnt_q == US_W'(clk_per_us - 1));
    assign ms_tick   = us_tick && (ms_cnt_q == MS_W'(999));
    assign half_tick = ms_tick && (half_cnt_q == HALF_W'(blink_half_ms - 1));

    // --------------------
    // tick chain
    // --------------------
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            us_cnt_q   <= '0;
            ms_cnt_q   <= '0;
            half_cnt_q <= '0;
            blink_q    <= 1'b0;
        end else begin
            // clocks per microsecond
            if (us_tick) begin
                us_cnt_q <= '0;
            end else begin
                us_cnt_q <= us_cnt_q + 1'b1;
            end
            // microseconds per millisecond
            if (ms_tick) begin
                ms_cnt_q <= '0;
            end else if (us_tick) begin
                ms_cnt_q <= ms_cnt_q + 1'b1;
            end
            // milliseconds per half period
            if (half_tick) begin
                half_cnt_q <= '0;
                blink_q    <= !blink_q;
            end else if (ms_tick) begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
        end
    end

    // dark while the link is held in reset
    assign led_o = blink_q && !link_rst_i;

endmodule

//--- hdl/link_port_mux.sv
/*
 * link stream port mux
 * selected rx head goes to the link, link rx beats go to the selected port
 */
`timescale 1ns/100ps

module link_port_mux #(
    parameter int nports = eth_link_pkg::NPORTS_DEF
) (
    input  eth_link_pkg::port_sel_t  sel_eth_ch_i,
    input  eth_link_pkg::link_beat_t rx_heads_i [nports],
    output logic [nports-1:0]        rx_pops_o,
    input  logic                     link_tx_ready_i,
    output eth_link_pkg::link_beat_t link_tx_o,
    input  eth_link_pkg::link_beat_t link_rx_i,
    output eth_link_pkg::link_beat_t tx_pushes_o [nports]
);

    // --------------------
    // port to link
    // --------------------
    // idle beat when the index has no port
    always_comb begin
        link_tx_o = '0;
        rx_pops_o = '0;
        for (int i = 0; i < nports; i++) begin
            if (sel_eth_ch_i == eth_link_pkg::port_sel_t'(i)) begin
                link_tx_o    = rx_heads_i[i];
                // pop on transfer only
                rx_pops_o[i] = rx_heads_i[i].valid && link_tx_ready_i;
            end
        end
    end

    // --------------------
    // link to port
    // --------------------
    // other ports see idle beats
    always_comb begin
        for (int i = 0; i < nports; i++) begin
            if (sel_eth_ch_i == eth_link_pkg::port_sel_t'(i)) begin
                tx_pushes_o[i] = link_rx_i;
            end else begin
                tx_pushes_o[i] = '0;
            end
        end
    end

endmodule

//--- hdl/eth_port_channel.sv
/*
 * one ethernet port of the switch
 * enable and status qualification, rx and tx frame fifos, mac tx sof
 */
`timescale 1ns/100ps

module eth_port_channel #(
    parameter int port_idx   = 0,
    parameter int fifo_depth = eth_link_pkg::FIFO_DEPTH_DEF
) (
    input  logic                       clk20_g,
    input  logic                       arst_n_i,
    input  eth_link_pkg::port_sel_t    sel_eth_ch_i,
    input  logic                       sel_link_i,
    input  logic                       link_tx_lock_i,
    input  eth_link_pkg::mac_status_t  mac_status_i,
    input  eth_link_pkg::mac_rx_beat_t mac_rx_i,
    output eth_link_pkg::link_beat_t   rx_head_o,
    input  logic                       rx_pop_i,
    input  eth_link_pkg::link_beat_t   tx_push_i,
    output eth_link_pkg::mac_tx_beat_t mac_tx_o,
    output logic                       overflow_o
);

    logic                    port_en;
    logic                    link_ok;
    logic                    flush;
    logic                    rx_in_valid_q;
    eth_link_pkg::rx_entry_t rx_in_q;
    eth_link_pkg::rx_entry_t rx_head;
    logic                    rx_empty;
    eth_link_pkg::tx_entry_t tx_wr_entry;
    eth_link_pkg::tx_entry_t tx_head;
    logic                    tx_empty;
    logic                    tx_pop;
    logic                    sof_next_q;
    logic                    tx_out_valid_q;
    logic                    tx_out_sof_q;
    eth_link_pkg::tx_entry_t tx_out_q;

    // --------------------
    // enable and status
    // --------------------
    // selected, link chosen and transceiver locked
    assign port_en = sel_link_i && link_tx_lock_i &&
                     (sel_eth_ch_i == eth_link_pkg::port_sel_t'(port_idx));
    // receive only at link up 1G
    assign link_ok = mac_status_i.link_up && (mac_status_i.speed == eth_link_pkg::SPEED_1G);
    // idle port holds both fifos empty
    assign flush   = !port_en;

    // --------------------
    // mac rx toward link
    // --------------------
    // input stage, one cycle before the fifo write
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_in_valid_q <= 1'b0;
        end else begin
            rx_in_valid_q <= mac_rx_i.valid && port_en && link_ok;
        end
    end

    always_ff @(posedge clk20_g) begin
        rx_in_q.data <= mac_rx_i.data;
        rx_in_q.last <= mac_rx_i.last;
        rx_in_q.bad  <= mac_rx_i.bad;
    end

    frame_fifo #(
        .entry_t (eth_link_pkg::rx_entry_t),
        .depth   (fifo_depth)
    ) rx_fifo_inst (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush),
        .wr_i       (rx_in_valid_q),
        .wr_data_i  (rx_in_q),
        .rd_i       (rx_pop_i),
        .rd_data_o  (rx_head),
        .empty_o    (rx_empty),
        .overflow_o (overflow_o)
    );

    // fifo head as a link beat
    always_comb begin
        rx_head_o.valid = !rx_empty && port_en;
        rx_head_o.data  = rx_head.data;
        rx_head_o.last  = rx_head.last;
        rx_head_o.bad   = rx_head.bad;
    end

    // --------------------
    // link rx toward mac
    // --------------------
    assign tx_wr_entry.data = tx_push_i.data;
    assign tx_wr_entry.last = tx_push_i.last;

    frame_fifo #(
        .entry_t (eth_link_pkg::tx_entry_t),
        .depth   (fifo_depth)
    ) tx_fifo_inst (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush),
        .wr_i       (tx_push_i.valid),
        .wr_data_i  (tx_wr_entry),
        .rd_i       (tx_pop),
        .rd_data_o  (tx_head),
        .empty_o    (tx_empty),
        .overflow_o ()
    );

    // mac side never stalls
    assign tx_pop = !tx_empty && port_en;

    // sof armed after reset, flush or a last beat
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sof_next_q     <= 1'b1;
            tx_out_valid_q <= 1'b0;
        end else if (flush) begin
            sof_next_q     <= 1'b1;
            tx_out_valid_q <= 1'b0;
        end else begin
            tx_out_valid_q <= tx_pop;
            if (tx_pop) begin
                sof_next_q <= tx_head.last;
            end
        end
    end

    // output beat register
    always_ff @(posedge clk20_g) begin
        if (tx_pop) begin
            tx_out_q     <= tx_head;
            tx_out_sof_q <= sof_next_q;
        end
    end

    always_comb begin
        mac_tx_o.valid = tx_out_valid_q;
        mac_tx_o.data  = tx_out_q.data;
        mac_tx_o.sof   = tx_out_sof_q;
        mac_tx_o.last  = tx_out_q.last;
    end

endmodule

//--- hdl/frame_fifo.sv
/*
 * frame fifo, circular buffer with flush
 * drops writes while full and latches a sticky overflow flag
 */
`timescale 1ns/100ps

module frame_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 16
) (
    input  logic   clk20_g,
    input  logic   arst_n_i,
    input  logic   flush_i,
    input  logic   wr_i,
    input  entry_t wr_data_i,
    input  logic   rd_i,
    output entry_t rd_data_o,
    output logic   empty_o,
    output logic   overflow_o
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    entry_t           mem [depth];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_rd;
    logic             do_wr;
    logic             overflow_q;

    // pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty_o = (count_q == '0);
    assign full    = (count_q == CNT_W'(depth));

    // flush wins over both ports
    assign do_rd = rd_i && !empty_o && !flush_i;
    // a read in the same cycle frees a slot
    assign do_wr = wr_i && !flush_i && (!full || do_rd);

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // sticky until flush
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            overflow_q <= 1'b0;
        end else if (flush_i) begin
            overflow_q <= 1'b0;
        end else if (wr_i && full && !do_rd) begin
            overflow_q <= 1'b1;
        end
    end

    always_ff @(posedge clk20_g) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // head is visible right after the write edge
    assign rd_data_o  = mem[rd_ptr_q];
    assign overflow_o = overflow_q;

endmodule

//--- hdl/eth_link_pkg.sv
/*
 * ethernet port switch shared types
 * beat structs, status layout and default sizing
 */
package eth_link_pkg;

    // --------------------
    // default sizing
    // --------------------
    localparam int NPORTS_DEF        = 4;
    localparam int FIFO_DEPTH_DEF    = 16;
    // clk20_g at 20 MHz
    localparam int CLK_PER_US_DEF    = 20;
    localparam int BLINK_HALF_MS_DEF = 125;

    // active port index
    typedef logic [1:0] port_sel_t;

    typedef logic [7:0] byte_t;

    // --------------------
    // mac status nibble
    // --------------------
    // bit 0 link, bits 2:1 speed, bit 3 spare
    typedef struct packed {
        logic       spare;
        logic [1:0] speed;
        logic       link_up;
    } mac_status_t;

    localparam logic [1:0] SPEED_1G = 2'b10;

    // --------------------
    // stream beats
    // --------------------
    // mac receiver beat, bad marks a broken frame
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  last;
        logic  bad;
    } mac_rx_beat_t;

    // mac transmitter beat
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  sof;
        logic  last;
    } mac_tx_beat_t;

    // link stream beat, both directions
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  last;
        logic  bad;
    } link_beat_t;

    // fifo payloads, valid is implied by occupancy
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  bad;
    } rx_entry_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } tx_entry_t;

endpackage
